//--- common/rx_ppe_pkg.sv
/* widths and enums shared by the rx packet processing stage
   table depth follows KEY_W; entries are loose fields, ENTRY_W is their sum
   pkt_type_t codes match the ingress metadata encoding */
package rx_ppe_pkg;

  // --------------------------------------------------
  // field widths
  // --------------------------------------------------
  // destination key, also the table address
  parameter int KEY_W = 6;
  // packet id from ingress
  parameter int ID_W = 8;
  // egress port
  parameter int PORT_W = 6;
  // traffic class
  parameter int TC_W = 3;
  // policer index
  parameter int POL_W = 10;

  // table entry = valid + port + tc + policer
  parameter int ENTRY_W = 1 + PORT_W + TC_W + POL_W;

  // --------------------------------------------------
  // packet type, carried through unchanged
  // --------------------------------------------------
  typedef enum logic [3:0] {
    MC        = 4'h0,
    UC        = 4'h1,
    MIRROR_MC = 4'h2,
    MIRROR_UC = 4'h3,
    INT_MC    = 4'h4,
    INT_UC    = 4'h5,
    // 6 and 7 unused
    VP_MC     = 4'h8,
    VP_UC     = 4'h9
  } pkt_type_t;

  // --------------------------------------------------
  // lane state machine
  // --------------------------------------------------
  typedef enum logic [1:0] {
    // slot empty
    IDLE = 2'd0,
    // head held, waiting for grant
    REQ  = 2'd1,
    // table read in flight
    WAIT = 2'd2
  } lane_state_t;

endpackage

//--- rx_ppe/fwd_table.sv
`timescale 1ns/1ps
/* forwarding table, one write port for software, one read port
   read data registered, one cycle latency; same address read+write returns old entry
   contents have no reset, every entry must be written before use */
module fwd_table
  import rx_ppe_pkg::*;
#(
  parameter int DEPTH = 64
) (
  input  logic              cclk,
  input  logic              rst,
  // software write port
  input  logic              cfg_wr_en,
  input  logic [KEY_W-1:0]  cfg_addr,
  input  logic              cfg_valid,
  input  logic [PORT_W-1:0] cfg_port,
  input  logic [TC_W-1:0]   cfg_tc,
  input  logic [POL_W-1:0]  cfg_policer,
  // arbitrated read port
  input  logic              rd_en,
  input  logic [KEY_W-1:0]  rd_addr,
  output logic              rd_entry_valid,
  output logic [PORT_W-1:0] rd_port,
  output logic [TC_W-1:0]   rd_tc,
  output logic [POL_W-1:0]  rd_policer
);

  // packed as {valid, port, tc, policer}
  logic [ENTRY_W-1:0] mem [DEPTH];
  logic [ENTRY_W-1:0] rd_data;

  // --------------------------------------------------
  // write, visible from the next edge
  // --------------------------------------------------
  always_ff @(posedge cclk) begin
    if (cfg_wr_en) begin
      mem[cfg_addr] <= {cfg_valid, cfg_port, cfg_tc, cfg_policer};
    end
  end

  // read side; nonblocking so a colliding write lands after the read
  always_ff @(posedge cclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  assign {rd_entry_valid, rd_port, rd_tc, rd_policer} = rd_data;

  // key space may be wider than the table when DEPTH is trimmed
  a_addr_range: assert property (@(posedge cclk) disable iff (rst)
    (cfg_wr_en |-> int'(cfg_addr) < DEPTH) and (rd_en |-> int'(rd_addr) < DEPTH))
    else $error("table address out of range");

endmodule

//--- rx_ppe/fwd_arbiter.sv
`timescale 1ns/1ps
/* two-lane round-robin arbiter for the table read port
   grant is combinational in the request cycle
   rd_valid follows one cycle later
   lane 0 has priority out of reset */
module fwd_arbiter
  import rx_ppe_pkg::*;
(
  input  logic             cclk,
  input  logic             rst,
  // lane 0
  input  logic             req0,
  input  logic [KEY_W-1:0] key0,
  // lane 1
  input  logic             req1,
  input  logic [KEY_W-1:0] key1,
  output logic             gnt0,
  output logic             gnt1,
  output logic             rd_valid0,
  output logic             rd_valid1,
  // to table
  output logic             rd_en,
  output logic [KEY_W-1:0] rd_addr
);

  // high when lane 1 took the most recent grant
  logic last_gnt1;

  // --------------------------------------------------
  // grant
  // --------------------------------------------------
  // on a tie the lane that lost last time wins
  assign gnt0 = req0 && (!req1 || last_gnt1);
  assign gnt1 = req1 && (!req0 || !last_gnt1);

  // steer winner key to the table
  assign rd_en   = gnt0 || gnt1;
  assign rd_addr = gnt1 ? key1 : key0;

  always_ff @(posedge cclk) begin
    if (rst) begin
      // makes lane 0 the first tie winner
      last_gnt1 <= 1'b1;
    end else if (rd_en) begin
      last_gnt1 <= gnt1;
    end
  end

  // --------------------------------------------------
  // read owner one cycle behind the grant
  // --------------------------------------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      rd_valid0 <= 1'b0;
      rd_valid1 <= 1'b0;
    end else begin
      rd_valid0 <= gnt0;
      rd_valid1 <= gnt1;
    end
  end

  // a lane turned away once must win on its next try
  a_no_starve0: assert property (@(posedge cclk) disable iff (rst)
    req0 && !gnt0 |=> !req0 || gnt0)
    else $error("lane 0 lost two grants in a row");

  a_no_starve1: assert property (@(posedge cclk) disable iff (rst)
    req1 && !gnt1 |=> !req1 || gnt1)
    else $error("lane 1 lost two grants in a row");

endmodule

//--- rx_ppe/ppe_lane.sv
`timescale 1ns/1ps
/* one ingress lane: single head slot, table lookup, fixed delay line
   ingress holds the head until ack; a new head is taken as the read returns
   results have no back-pressure, PIPE_DEPTH must be at least 1 */
module ppe_lane
  import rx_ppe_pkg::*;
#(
  parameter int PIPE_DEPTH = 8
) (
  input  logic              cclk,
  input  logic              rst,
  // ingress head
  input  logic              head_valid,
  input  logic [ID_W-1:0]   head_id,
  input  logic [KEY_W-1:0]  head_key,
  input  pkt_type_t         head_type,
  output logic              head_ack,
  // lookup
  output logic              req,
  output logic [KEY_W-1:0]  key,
  input  logic              gnt,
  input  logic              rd_valid,
  input  logic              rd_entry_valid,
  input  logic [PORT_W-1:0] rd_port,
  input  logic [TC_W-1:0]   rd_tc,
  input  logic [POL_W-1:0]  rd_policer,
  // result metadata
  output logic              out_valid,
  output logic [ID_W-1:0]   out_id,
  output logic [PORT_W-1:0] out_port,
  output logic [TC_W-1:0]   out_tc,
  output logic [POL_W-1:0]  out_policer,
  output pkt_type_t         out_type,
  output logic              out_drop
);

  lane_state_t      state;
  logic [ID_W-1:0]  slot_id;
  logic [KEY_W-1:0] slot_key;
  pkt_type_t        slot_type;
  logic             rd_done;
  logic             slot_free;

  // result built from the returned entry
  logic [PORT_W-1:0] res_port;
  logic [TC_W-1:0]   res_tc;
  logic [POL_W-1:0]  res_pol;
  logic              res_drop;

  // delay line, one entry per stage
  logic [PIPE_DEPTH-1:0] pipe_valid;
  logic [ID_W-1:0]       pipe_id   [PIPE_DEPTH];
  logic [PORT_W-1:0]     pipe_port [PIPE_DEPTH];
  logic [TC_W-1:0]       pipe_tc   [PIPE_DEPTH];
  logic [POL_W-1:0]      pipe_pol  [PIPE_DEPTH];
  pkt_type_t             pipe_type [PIPE_DEPTH];
  logic [PIPE_DEPTH-1:0] pipe_drop;

  // --------------------------------------------------
  // head slot and state machine
  // --------------------------------------------------
  assign rd_done = (state == WAIT) && rd_valid;
  // slot counts as empty in the cycle its read returns
  assign slot_free = (state == IDLE) || rd_done;
  assign head_ack  = head_valid && slot_free;

  assign req = (state == REQ);
  assign key = slot_key;

  always_ff @(posedge cclk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (head_valid) state <= REQ;
        REQ:     if (gnt) state <= WAIT;
        // back to back: next head goes straight to REQ
        WAIT:    if (rd_valid) state <= head_valid ? REQ : IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge cclk) begin
    if (head_ack) begin
      slot_id   <= head_id;
      slot_key  <= head_key;
      slot_type <= head_type;
    end
  end

  // --------------------------------------------------
  // metadata build
  // --------------------------------------------------
  always_comb begin
    // miss -> drop, fields zeroed
    res_drop = !rd_entry_valid;
    res_port = rd_entry_valid ? rd_port : '0;
    res_tc   = rd_entry_valid ? rd_tc : '0;
    res_pol  = rd_entry_valid ? rd_policer : '0;
  end

  // --------------------------------------------------
  // latency delay line
  // --------------------------------------------------
  always_ff @(posedge cclk) begin
    if (rst) begin
      pipe_valid <= '0;
      out_valid  <= 1'b0;
    end else begin
      pipe_valid[0] <= rd_done;
      for (int i = 1; i < PIPE_DEPTH; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
      end
      out_valid <= pipe_valid[PIPE_DEPTH-1];
    end
  end

  // payload follows the valid bits
  always_ff @(posedge cclk) begin
    pipe_id[0]   <= slot_id;
    pipe_port[0] <= res_port;
    pipe_tc[0]   <= res_tc;
    pipe_pol[0]  <= res_pol;
    pipe_type[0] <= slot_type;
    pipe_drop[0] <= res_drop;
    for (int i = 1; i < PIPE_DEPTH; i++) begin
      pipe_id[i]   <= pipe_id[i-1];
      pipe_port[i] <= pipe_port[i-1];
      pipe_tc[i]   <= pipe_tc[i-1];
      pipe_pol[i]  <= pipe_pol[i-1];
      pipe_type[i] <= pipe_type[i-1];
      pipe_drop[i] <= pipe_drop[i-1];
    end
    // output register, one cycle past the last stage
    out_id      <= pipe_id[PIPE_DEPTH-1];
    out_port    <= pipe_port[PIPE_DEPTH-1];
    out_tc      <= pipe_tc[PIPE_DEPTH-1];
    out_policer <= pipe_pol[PIPE_DEPTH-1];
    out_type    <= pipe_type[PIPE_DEPTH-1];
    out_drop    <= pipe_drop[PIPE_DEPTH-1];
  end

  // arbiter must only return data for a read this lane issued
  a_rd_in_wait: assert property (@(posedge cclk) disable iff (rst)
    rd_valid |-> state == WAIT)
    else $error("rd_valid outside WAIT");

endmodule

//--- src/rx_ppe_top.sv
`timescale 1ns/1ps
/* rx packet processing stage: two ingress lanes sharing one forwarding table
   latency per head is PIPE_DEPTH+2 or PIPE_DEPTH+3 cycles
   table must be written by software before traffic starts */
module rx_ppe_top
  import rx_ppe_pkg::*;
#(
  parameter int PIPE_DEPTH = 8
) (
  input  logic              cclk,
  input  logic              rst,
  // software table write
  input  logic              cfg_wr_en,
  input  logic [KEY_W-1:0]  cfg_addr,
  input  logic              cfg_valid,
  input  logic [PORT_W-1:0] cfg_port,
  input  logic [TC_W-1:0]   cfg_tc,
  input  logic [POL_W-1:0]  cfg_policer,
  // lane 0 head
  input  logic              head_valid_0,
  input  logic [ID_W-1:0]   head_id_0,
  input  logic [KEY_W-1:0]  head_key_0,
  input  pkt_type_t         head_type_0,
  output logic              head_ack_0,
  // lane 1 head
  input  logic              head_valid_1,
  input  logic [ID_W-1:0]   head_id_1,
  input  logic [KEY_W-1:0]  head_key_1,
  input  pkt_type_t         head_type_1,
  output logic              head_ack_1,
  // lane 0 result
  output logic              out_valid_0,
  output logic [ID_W-1:0]   out_id_0,
  output logic [PORT_W-1:0] out_port_0,
  output logic [TC_W-1:0]   out_tc_0,
  output logic [POL_W-1:0]  out_policer_0,
  output pkt_type_t         out_type_0,
  output logic              out_drop_0,
  // lane 1 result
  output logic              out_valid_1,
  output logic [ID_W-1:0]   out_id_1,
  output logic [PORT_W-1:0] out_port_1,
  output logic [TC_W-1:0]   out_tc_1,
  output logic [POL_W-1:0]  out_policer_1,
  output pkt_type_t         out_type_1,
  output logic              out_drop_1
);

  logic             req0, req1, gnt0, gnt1;
  logic             rd_valid0, rd_valid1;
  logic [KEY_W-1:0] key0, key1;
  logic             rd_en;
  logic [KEY_W-1:0] rd_addr;

  // entry read data, shared by both lanes
  logic              rd_entry_valid;
  logic [PORT_W-1:0] rd_port;
  logic [TC_W-1:0]   rd_tc;
  logic [POL_W-1:0]  rd_policer;

  // --------------------------------------------------
  // lanes
  // --------------------------------------------------
  ppe_lane #(.PIPE_DEPTH(PIPE_DEPTH)) i_lane0 (
    .cclk(cclk), .rst(rst),
    .head_valid(head_valid_0), .head_id(head_id_0), .head_key(head_key_0),
    .head_type(head_type_0), .head_ack(head_ack_0),
    .req(req0), .key(key0), .gnt(gnt0), .rd_valid(rd_valid0),
    .rd_entry_valid(rd_entry_valid), .rd_port(rd_port), .rd_tc(rd_tc),
    .rd_policer(rd_policer),
    .out_valid(out_valid_0), .out_id(out_id_0), .out_port(out_port_0), .out_tc(out_tc_0),
    .out_policer(out_policer_0), .out_type(out_type_0), .out_drop(out_drop_0)
  );

  ppe_lane #(.PIPE_DEPTH(PIPE_DEPTH)) i_lane1 (
    .cclk(cclk), .rst(rst),
    .head_valid(head_valid_1), .head_id(head_id_1), .head_key(head_key_1),
    .head_type(head_type_1), .head_ack(head_ack_1),
    .req(req1), .key(key1), .gnt(gnt1), .rd_valid(rd_valid1),
    .rd_entry_valid(rd_entry_valid), .rd_port(rd_port), .rd_tc(rd_tc),
    .rd_policer(rd_policer),
    .out_valid(out_valid_1), .out_id(out_id_1), .out_port(out_port_1), .out_tc(out_tc_1),
    .out_policer(out_policer_1), .out_type(out_type_1), .out_drop(out_drop_1)
  );

  // --------------------------------------------------
  // shared lookup
  // --------------------------------------------------
  fwd_arbiter i_arb (
    .cclk(cclk), .rst(rst),
    .req0(req0), .key0(key0), .req1(req1), .key1(key1),
    .gnt0(gnt0), .gnt1(gnt1), .rd_valid0(rd_valid0), .rd_valid1(rd_valid1),
    .rd_en(rd_en), .rd_addr(rd_addr)
  );

  fwd_table #(.DEPTH(2 ** KEY_W)) i_table (
    .cclk(cclk), .rst(rst),
    .cfg_wr_en(cfg_wr_en), .cfg_addr(cfg_addr), .cfg_valid(cfg_valid),
    .cfg_port(cfg_port), .cfg_tc(cfg_tc), .cfg_policer(cfg_policer),
    .rd_en(rd_en), .rd_addr(rd_addr),
    .rd_entry_valid(rd_entry_valid), .rd_port(rd_port), .rd_tc(rd_tc),
    .rd_policer(rd_policer)
  );

endmodule

//--- test/tb_rx_ppe_checks.sv
`timescale 1ns/1ps
/* scoreboard and protocol checks for rx_ppe_top, every DUT port connected by name
   samples on the falling edge, when inputs and registered outputs are settled
   mirror table follows the cfg write port, so traffic must come after the table fill */
module tb_rx_ppe_checks
  import rx_ppe_pkg::*;
#(
  parameter int PIPE_DEPTH = 8
) (
  input  logic              cclk,
  input  logic              rst,
  input  int                cycle,
  input  logic              cfg_wr_en,
  input  logic [KEY_W-1:0]  cfg_addr,
  input  logic              cfg_valid,
  input  logic [PORT_W-1:0] cfg_port,
  input  logic [TC_W-1:0]   cfg_tc,
  input  logic [POL_W-1:0]  cfg_policer,
  input  logic              head_valid_0, head_ack_0, head_valid_1, head_ack_1,
  input  logic [ID_W-1:0]   head_id_0, head_id_1,
  input  logic [KEY_W-1:0]  head_key_0, head_key_1,
  input  pkt_type_t         head_type_0, head_type_1,
  input  logic              out_valid_0, out_drop_0, out_valid_1, out_drop_1,
  input  logic [ID_W-1:0]   out_id_0, out_id_1,
  input  logic [PORT_W-1:0] out_port_0, out_port_1,
  input  logic [TC_W-1:0]   out_tc_0, out_tc_1,
  input  logic [POL_W-1:0]  out_policer_0, out_policer_1,
  input  pkt_type_t         out_type_0, out_type_1,
  output int                errors,
  output int                results,
  output int                pending
);

  typedef struct packed {
    logic              valid;
    logic [PORT_W-1:0] port;
    logic [TC_W-1:0]   tc;
    logic [POL_W-1:0]  pol;
  } entry_t;

  // one record per transferred head, cyc is the transfer edge
  typedef struct packed {
    logic [ID_W-1:0]  id;
    logic [KEY_W-1:0] key;
    pkt_type_t        ptype;
    int               cyc;
  } head_rec_t;

  entry_t    mirror [2**KEY_W];
  head_rec_t pend0 [$];
  head_rec_t pend1 [$];
  int        check_err = 0;
  int        assert_err = 0;

  assign errors = check_err + assert_err;

  function automatic head_rec_t make_record(input logic [ID_W-1:0] id,
                                            input logic [KEY_W-1:0] key,
                                            input pkt_type_t ptype, input int cyc);
    head_rec_t rec;
    rec.id    = id;
    rec.key   = key;
    rec.ptype = ptype;
    rec.cyc   = cyc;
    return rec;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      check_err++;
    end
  endtask

  task automatic report_stray(input int lane);
    $display("lane %0d gave a result with no head transferred", lane);
    check_err++;
  endtask

  task automatic check_result(input int lane, input head_rec_t rec, input logic [ID_W-1:0] id,
                              input logic [PORT_W-1:0] port, input logic [TC_W-1:0] tc,
                              input logic [POL_W-1:0] pol, input pkt_type_t ptype,
                              input logic drop);
    entry_t ent;
    int     lat;
    ent = mirror[rec.key];
    lat = cycle - rec.cyc;
    results++;
    check_value($sformatf("out_id_%0d", lane), 32'(rec.id), 32'(id));
    check_value($sformatf("out_type_%0d", lane), 32'(rec.ptype), 32'(ptype));
    // miss zeroes the entry fields and sets drop
    check_value($sformatf("out_drop_%0d", lane), 32'(!ent.valid), 32'(drop));
    check_value($sformatf("out_port_%0d", lane), ent.valid ? 32'(ent.port) : 32'd0, 32'(port));
    check_value($sformatf("out_tc_%0d", lane), ent.valid ? 32'(ent.tc) : 32'd0, 32'(tc));
    check_value($sformatf("out_policer_%0d", lane), ent.valid ? 32'(ent.pol) : 32'd0, 32'(pol));
    // one extra cycle allowed when the other lane holds the turn
    assert (lat >= PIPE_DEPTH + 2 && lat <= PIPE_DEPTH + 3) else begin
      $display("lane %0d head id %h took %0d cycles, outside %0d to %0d", lane, rec.id, lat,
               PIPE_DEPTH + 2, PIPE_DEPTH + 3);
      check_err++;
    end
  endtask

  // --------------------------------------------------
  // scoreboard, falling edge
  // --------------------------------------------------
  always @(negedge cclk) begin
    if (!rst) begin
      if (cfg_wr_en) begin
        mirror[cfg_addr] = '{cfg_valid, cfg_port, cfg_tc, cfg_policer};
      end
      // valid and ack now means a transfer at the coming rising edge
      if (head_valid_0 && head_ack_0) begin
        pend0.push_back(make_record(head_id_0, head_key_0, head_type_0, cycle + 1));
      end
      if (head_valid_1 && head_ack_1) begin
        pend1.push_back(make_record(head_id_1, head_key_1, head_type_1, cycle + 1));
      end
      if (out_valid_0) begin
        if (pend0.size() == 0) begin
          report_stray(0);
        end else begin
          check_result(0, pend0.pop_front(), out_id_0, out_port_0, out_tc_0, out_policer_0,
                       out_type_0, out_drop_0);
        end
      end
      if (out_valid_1) begin
        if (pend1.size() == 0) begin
          report_stray(1);
        end else begin
          check_result(1, pend1.pop_front(), out_id_1, out_port_1, out_tc_1, out_policer_1,
                       out_type_1, out_drop_1);
        end
      end
    end
    pending = pend0.size() + pend1.size();
  end

  // --------------------------------------------------
  // head handshake rules
  // --------------------------------------------------
  a_ack_needs_valid: assert property (@(negedge cclk) disable iff (rst)
    (!head_ack_0 || head_valid_0) && (!head_ack_1 || head_valid_1))
    else begin
      $display("head_ack raised with no head_valid");
      assert_err++;
    end

  // slot is busy in the cycle after a transfer
  a_busy_0: assert property (@(negedge cclk) disable iff (rst)
    head_valid_0 && head_ack_0 |=> !head_ack_0)
    else begin
      $display("lane 0 acked a new head right after a transfer");
      assert_err++;
    end

  a_busy_1: assert property (@(negedge cclk) disable iff (rst)
    head_valid_1 && head_ack_1 |=> !head_ack_1)
    else begin
      $display("lane 1 acked a new head right after a transfer");
      assert_err++;
    end

endmodule

//--- test/tb_rx_ppe.sv
`timescale 1ns/1ps
/* testbench for rx_ppe_top at PIPE_DEPTH 8, checking is done in the checks instance
   inputs change 10 ns after the rising edge; $urandom seed 44
   run is capped at 3000 cycles */
module tb_rx_ppe
  import rx_ppe_pkg::*;
();

  localparam int PIPE_DEPTH     = 8;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int BURST          = 60;

  logic              cclk, rst;
  logic              cfg_wr_en, cfg_valid;
  logic [KEY_W-1:0]  cfg_addr;
  logic [PORT_W-1:0] cfg_port;
  logic [TC_W-1:0]   cfg_tc;
  logic [POL_W-1:0]  cfg_policer;
  logic              head_valid_0, head_ack_0, head_valid_1, head_ack_1;
  logic [ID_W-1:0]   head_id_0, head_id_1;
  logic [KEY_W-1:0]  head_key_0, head_key_1;
  pkt_type_t         head_type_0, head_type_1;
  logic              out_valid_0, out_drop_0, out_valid_1, out_drop_1;
  logic [ID_W-1:0]   out_id_0, out_id_1;
  logic [PORT_W-1:0] out_port_0, out_port_1;
  logic [TC_W-1:0]   out_tc_0, out_tc_1;
  logic [POL_W-1:0]  out_policer_0, out_policer_1;
  pkt_type_t         out_type_0, out_type_1;

  int cycle = 0;
  int errors, results, pending;
  int tb_err = 0;
  int test_num = 0;
  int err_mark = 0;

  rx_ppe_top #(.PIPE_DEPTH(PIPE_DEPTH)) i_dut (.*);

  tb_rx_ppe_checks #(.PIPE_DEPTH(PIPE_DEPTH)) i_checks (.*);

  initial begin
    cclk = 1'b0;
    forever #50 cclk = ~cclk;
  end

  always @(posedge cclk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("run stopped at the limit of %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  function automatic pkt_type_t type_from_index(input int n);
    case (n)
      0: return MC;
      1: return UC;
      2: return MIRROR_MC;
      3: return MIRROR_UC;
      4: return INT_MC;
      5: return INT_UC;
      6: return VP_MC;
      default: return VP_UC;
    endcase
  endfunction

  // present a head and hold it until the transfer edge, count cycles without ack
  task automatic send_head(input int lane, input logic [ID_W-1:0] id,
                           input logic [KEY_W-1:0] key, input pkt_type_t ptype,
                           output int waits);
    logic acked;
    if (lane == 0) begin
      head_valid_0 = 1'b1;
      head_id_0    = id;
      head_key_0   = key;
      head_type_0  = ptype;
    end else begin
      head_valid_1 = 1'b1;
      head_id_1    = id;
      head_key_1   = key;
      head_type_1  = ptype;
    end
    waits = 0;
    acked = 1'b0;
    while (!acked) begin
      @(negedge cclk);
      acked = (lane == 0) ? head_ack_0 : head_ack_1;
      if (!acked) waits++;
    end
    @(posedge cclk);
    #10;
  endtask

  task automatic release_head(input int lane);
    if (lane == 0) head_valid_0 = 1'b0;
    else head_valid_1 = 1'b0;
  endtask

  task automatic fill_table;
    for (int a = 0; a < 2 ** KEY_W; a++) begin
      cfg_wr_en   = 1'b1;
      cfg_addr    = KEY_W'(a);
      // about one in four misses; key 0 always hits, key 1 always misses
      cfg_valid   = (a == 0) || (a != 1 && ($urandom % 4) != 0);
      cfg_port    = PORT_W'($urandom);
      cfg_tc      = TC_W'($urandom);
      cfg_policer = POL_W'($urandom);
      @(posedge cclk);
      #10;
    end
    cfg_wr_en = 1'b0;
  endtask

  task automatic wait_drain;
    @(posedge cclk);
    while (pending != 0) @(posedge cclk);
    #10;
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors + tb_err - err_mark;
    test_num++;
    $display("test %0d %s: %s, %0d errors", test_num, name, n == 0 ? "ok" : "bad", n);
    err_mark = errors + tb_err;
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int               seed_sink;
    int               waits, w0, w1;
    int               res_mark;
    logic [KEY_W-1:0] keys [2][BURST];
    pkt_type_t        types [2][BURST];
    seed_sink    = $urandom(44);
    rst          = 1'b1;
    cfg_wr_en    = 1'b0;
    cfg_addr     = '0;
    cfg_valid    = 1'b0;
    cfg_port     = '0;
    cfg_tc       = '0;
    cfg_policer  = '0;
    head_valid_0 = 1'b0;
    head_id_0    = '0;
    head_key_0   = '0;
    head_type_0  = MC;
    head_valid_1 = 1'b0;
    head_id_1    = '0;
    head_key_1   = '0;
    head_type_1  = MC;
    repeat (5) @(posedge cclk);
    #10;
    rst = 1'b0;

    // nothing sent, acks and results must stay low
    repeat (6) @(posedge cclk);
    #10;
    end_test("quiet after reset");

    fill_table();

    send_head(0, ID_W'(8'h11), KEY_W'(0), UC, waits);
    release_head(0);
    wait_drain();
    end_test("single hit on lane 0");

    // key 1 is a miss, walk all eight types
    for (int t = 0; t < 8; t++) begin
      send_head(0, ID_W'(8'h20 + t), KEY_W'(1), type_from_index(t), waits);
    end
    release_head(0);
    wait_drain();
    end_test("miss with all packet types");

    // second head is held while the first one is in lookup
    res_mark = results;
    send_head(0, ID_W'(8'h30), KEY_W'(2), MC, waits);
    send_head(0, ID_W'(8'h31), KEY_W'(3), VP_UC, waits);
    release_head(0);
    assert (waits >= 1) else begin
      $display("lane 0 took a second head while the first was still in lookup");
      tb_err++;
    end
    wait_drain();
    assert (results - res_mark == 2) else begin
      $display("FAIL results expected %h actual %h", 2, results - res_mark);
      tb_err++;
    end
    end_test("back-pressure");

    // keys and types drawn up front so both lanes see a fixed sequence
    for (int l = 0; l < 2; l++) begin
      for (int i = 0; i < BURST; i++) begin
        keys[l][i]  = KEY_W'($urandom);
        types[l][i] = type_from_index(int'($urandom % 8));
      end
    end
    res_mark = results;
    fork
      begin
        for (int i = 0; i < BURST; i++) begin
          send_head(0, ID_W'(i), keys[0][i], types[0][i], w0);
        end
        release_head(0);
      end
      begin
        for (int i = 0; i < BURST; i++) begin
          send_head(1, ID_W'(128 + i), keys[1][i], types[1][i], w1);
        end
        release_head(1);
      end
    join
    wait_drain();
    assert (results - res_mark == 2 * BURST) else begin
      $display("FAIL results expected %h actual %h", 2 * BURST, results - res_mark);
      tb_err++;
    end
    end_test("dual lane burst");

    $display("%0d tests, %0d results checked, %0d errors", test_num, results, errors + tb_err);
    if (errors + tb_err == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- filelist.f
common/rx_ppe_pkg.sv
rx_ppe/fwd_table.sv
rx_ppe/fwd_arbiter.sv
rx_ppe/ppe_lane.sv
src/rx_ppe_top.sv
test/tb_rx_ppe_checks.sv
test/tb_rx_ppe.sv

//--- run_sim.sh
#!/bin/sh
# build the rx_ppe testbench with Verilator and run it
# exit status is 0 only when the pass message shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -f filelist.f --top-module tb_rx_ppe -o sim_rx_ppe &&
./obj_dir/sim_rx_ppe | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation run passed" ||
{ echo "simulation run failed"; exit 1; }
